// File: src/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// fetch packet geometry
`define DEC_PACKET_BYTES 16
`define DEC_MAX_PREFIXES 3

// instruction pointer
`define DEC_EIP_W 32

// x86 caps an instruction at 15 bytes
`define DEC_MAX_LENGTH 15

// prefix bytes we recognise
`define DEC_PFX_REP    8'hF3  // rep / repe
`define DEC_PFX_OPSIZE 8'h66  // operand size override

// segment override prefixes
`define DEC_PFX_ES 8'h26
`define DEC_PFX_CS 8'h2E
`define DEC_PFX_SS 8'h36
`define DEC_PFX_DS 8'h3E
`define DEC_PFX_FS 8'h64
`define DEC_PFX_GS 8'h65

`endif

// File: src/decode_pkg.sv
`include "decode_defines.svh"

package decode_pkg;

    // width of any length field, 4 bits for a 15 byte max
    localparam int LEN_W = $clog2(`DEC_MAX_LENGTH + 1);

    // op_size codes
    localparam logic [1:0] OPSZ_8  = 2'd0;
    localparam logic [1:0] OPSZ_16 = 2'd1;
    localparam logic [1:0] OPSZ_32 = 2'd2;

    ////////////////////////////////////////////////////////////
    // raw packet, byte 0 sits at the msb end
    typedef logic [0:`DEC_PACKET_BYTES-1][7:0] packet_t;

    typedef enum logic [2:0] {
        SEG_NONE, SEG_ES, SEG_CS, SEG_SS, SEG_DS, SEG_FS, SEG_GS
    } seg_t;

    typedef struct packed {
        logic [1:0] num_prefixes;
        logic       rep;
        logic       opsize;
        seg_t       seg;          // last override wins
    } prefix_info_t;

    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {IMM_NONE, IMM_8, IMM_16, IMM_32} imm_size_t;

    typedef enum logic [2:0] {
        FORM_NONE,      // no operands (nop)
        FORM_MODRM,     // r/m addressed
        FORM_REG_OPC,   // register in opcode low bits
        FORM_ACC_IMM,   // eax, imm
        FORM_REL        // relative branch
    } op_form_t;

    typedef struct packed {
        logic [7:0] opcode;
        op_form_t   form;
        imm_size_t  imm_size;
        logic       has_modrm;
        logic       is_br;
        logic       illegal;
        logic [1:0] op_size;      // OPSZ_* codes
    } opcode_info_t;

    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {DISP_NONE, DISP_8, DISP_32} disp_size_t;

    typedef struct packed {
        logic [2:0] reg_num;      // modrm reg or opcode reg
        logic [2:0] base;
        logic [2:0] index;
        logic [1:0] scale;
        logic       use_base;
        logic       use_index;
        logic       has_sib;
        disp_size_t disp_size;
    } modrm_info_t;

    // control flow redirects from init, writeback and bp
    typedef struct packed {
        logic                  init;
        logic                  resteer;
        logic                  bp_taken;
        logic [`DEC_EIP_W-1:0] init_eip;
        logic [`DEC_EIP_W-1:0] resteer_eip;
        logic [`DEC_EIP_W-1:0] bp_eip;
    } redirect_t;

    // decoded instruction for rename
    typedef struct packed {
        logic [`DEC_EIP_W-1:0] eip;
        logic [`DEC_EIP_W-1:0] next_eip;
        logic [LEN_W-1:0]      length;
        prefix_info_t          pfx;
        opcode_info_t          opc;
        modrm_info_t           mrm;
        logic [31:0]           disp;
        logic [31:0]           imm;
        logic                  ie;       // illegal opcode
    } uop_t;

endpackage

// File: src/prefix_decode.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module prefix_decode
    import decode_pkg::*;
(
    input  packet_t      packet,
    output prefix_info_t pfx
);

    logic scanning;  // still inside the prefix run
    logic is_pfx;    // current byte matched a prefix

    // walk bytes 0..2, stop at first non prefix
    always_comb begin
        pfx      = '0;
        scanning = 1'b1;
        is_pfx   = 1'b0;
        for (int i = 0; i < `DEC_MAX_PREFIXES; i++) begin
            if (scanning) begin
                is_pfx = 1'b1;
                case (packet[i])
                    `DEC_PFX_REP:    pfx.rep    = 1'b1;
                    `DEC_PFX_OPSIZE: pfx.opsize = 1'b1;
                    `DEC_PFX_ES:     pfx.seg    = SEG_ES;
                    `DEC_PFX_CS:     pfx.seg    = SEG_CS;
                    `DEC_PFX_SS:     pfx.seg    = SEG_SS;
                    `DEC_PFX_DS:     pfx.seg    = SEG_DS;
                    `DEC_PFX_FS:     pfx.seg    = SEG_FS;
                    `DEC_PFX_GS:     pfx.seg    = SEG_GS;
                    default:         is_pfx     = 1'b0;  // opcode reached
                endcase
                if (is_pfx) begin
                    pfx.num_prefixes = pfx.num_prefixes + 2'd1;
                end else begin
                    scanning = 1'b0;
                end
            end
        end
    end

    // a repeated segment prefix simply overwrites the earlier one,
    // the count still includes every prefix byte

endmodule

// File: src/opcode_decode.sv
`timescale 1ns/1ns

module opcode_decode
    import decode_pkg::*;
(
    input  packet_t      packet,
    input  prefix_info_t pfx,
    output opcode_info_t opc
);

    logic [7:0] opc_byte;  // first byte after prefixes
    logic       wide;      // word/dword operand, else byte

    assign opc_byte = packet[pfx.num_prefixes];

    always_comb begin
        opc        = '0;
        opc.opcode = opc_byte;
        wide       = 1'b1;
        casez (opc_byte)
            8'b0000_00??: begin            // add r/m,r and r,r/m
                opc.form      = FORM_MODRM;
                opc.has_modrm = 1'b1;
                wide          = opc_byte[0];
            end
            8'h05: begin                   // add eax,imm
                opc.form     = FORM_ACC_IMM;
                opc.imm_size = IMM_32;
            end
            8'h81: begin                   // grp1 r/m,imm32
                opc.form      = FORM_MODRM;
                opc.has_modrm = 1'b1;
                opc.imm_size  = IMM_32;
            end
            8'h83: begin                   // grp1 r/m,imm8 sign extended
                opc.form      = FORM_MODRM;
                opc.has_modrm = 1'b1;
                opc.imm_size  = IMM_8;
            end
            8'b1000_10??: begin            // mov 88..8b
                opc.form      = FORM_MODRM;
                opc.has_modrm = 1'b1;
                wide          = opc_byte[0];
            end
            8'b1011_1???: begin            // mov r,imm32
                opc.form     = FORM_REG_OPC;
                opc.imm_size = IMM_32;
            end
            8'h90: opc.form = FORM_NONE;   // nop
            8'hEB: begin                   // jmp rel8
                opc.form     = FORM_REL;
                opc.imm_size = IMM_8;
                opc.is_br    = 1'b1;
            end
            8'hE9: begin                   // jmp rel32
                opc.form     = FORM_REL;
                opc.imm_size = IMM_32;
                opc.is_br    = 1'b1;
            end
            default: begin
                opc.illegal = 1'b1;
                wide        = 1'b0;        // keeps op_size at zero
            end
        endcase

        // 66 shrinks full size imm and operand to 16 bits
        if (pfx.opsize && opc.imm_size == IMM_32) begin
            opc.imm_size = IMM_16;
        end
        if (!wide) opc.op_size = OPSZ_8;
        else if (pfx.opsize) opc.op_size = OPSZ_16;
        else opc.op_size = OPSZ_32;
    end

endmodule

// File: src/modrm_decode.sv
`timescale 1ns/1ns

module modrm_decode
    import decode_pkg::*;
(
    input  packet_t      packet,
    input  prefix_info_t pfx,
    input  opcode_info_t opc,
    output modrm_info_t  mrm
);

    logic [3:0] mrm_idx;   // modrm byte position
    logic [7:0] modrm_b;
    logic [7:0] sib_b;

    assign mrm_idx = {2'b00, pfx.num_prefixes} + 4'd1;
    assign modrm_b = packet[mrm_idx];
    assign sib_b   = packet[mrm_idx + 4'd1];  // only meaningful when rm is 4

    always_comb begin
        mrm = '0;
        if (opc.form == FORM_REG_OPC) begin
            mrm.reg_num = opc.opcode[2:0];   // b8+r
        end else if (opc.has_modrm) begin
            mrm.reg_num = modrm_b[5:3];
            if (modrm_b[7:6] == 2'b11) begin
                // register direct
                mrm.base     = modrm_b[2:0];
                mrm.use_base = 1'b1;
            end else begin
                case (modrm_b[7:6])
                    2'b01:   mrm.disp_size = DISP_8;
                    2'b10:   mrm.disp_size = DISP_32;
                    default: mrm.disp_size = DISP_NONE;
                endcase
                if (modrm_b[2:0] == 3'd4) begin
                    // sib follows
                    mrm.has_sib = 1'b1;
                    if (sib_b[5:3] != 3'd4) begin  // index 4 means none
                        mrm.index     = sib_b[5:3];
                        mrm.scale     = sib_b[7:6];
                        mrm.use_index = 1'b1;
                    end
                    if (sib_b[2:0] == 3'd5 && modrm_b[7:6] == 2'b00) begin
                        mrm.disp_size = DISP_32;   // [index*s + disp32]
                    end else begin
                        mrm.base     = sib_b[2:0];
                        mrm.use_base = 1'b1;
                    end
                end else if (modrm_b[2:0] == 3'd5 && modrm_b[7:6] == 2'b00) begin
                    mrm.disp_size = DISP_32;       // absolute disp32
                end else begin
                    mrm.base     = modrm_b[2:0];
                    mrm.use_base = 1'b1;
                end
            end
        end
        // unused base/index/scale stay zero
    end

endmodule

// File: src/operand_extract.sv
`timescale 1ns/1ns

module operand_extract
    import decode_pkg::*;
(
    input  packet_t          packet,
    input  prefix_info_t     pfx,
    input  opcode_info_t     opc,
    input  modrm_info_t      mrm,
    output logic [LEN_W-1:0] length,
    output logic [31:0]      disp,
    output logic [31:0]      imm
);

    logic [3:0] disp_off;     // first disp byte
    logic [3:0] imm_off;      // first imm byte
    logic [2:0] disp_bytes;
    logic [2:0] imm_bytes;

    // little endian gather of up to 4 bytes, then sign extend
    function automatic logic [31:0] gather(input packet_t pkt, input logic [3:0] off,
                                           input logic [2:0] nbytes);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < 4; k++) begin
            if (k < int'(nbytes)) val[k*8 +: 8] = pkt[off + 4'(k)];
        end
        case (nbytes)
            3'd1:    val = {{24{val[7]}}, val[7:0]};
            3'd2:    val = {{16{val[15]}}, val[15:0]};
            default: ;                             // 0 or 4 already full width
        endcase
        return val;
    endfunction

    always_comb begin
        case (mrm.disp_size)
            DISP_8:  disp_bytes = 3'd1;
            DISP_32: disp_bytes = 3'd4;
            default: disp_bytes = 3'd0;
        endcase
        case (opc.imm_size)
            IMM_8:   imm_bytes = 3'd1;
            IMM_16:  imm_bytes = 3'd2;
            IMM_32:  imm_bytes = 3'd4;
            default: imm_bytes = 3'd0;
        endcase
        if (opc.illegal) begin       // prefixes plus the bad opcode only
            disp_bytes = 3'd0;
            imm_bytes  = 3'd0;
        end
    end

    // prefixes, opcode, modrm, sib, then disp and imm
    assign disp_off = {2'b00, pfx.num_prefixes} + 4'd1 + {3'b000, opc.has_modrm & ~opc.illegal}
                      + {3'b000, mrm.has_sib};
    assign imm_off  = disp_off + {1'b0, disp_bytes};
    assign length   = imm_off + {1'b0, imm_bytes};

    assign disp = gather(packet, disp_off, disp_bytes);
    assign imm  = gather(packet, imm_off, imm_bytes);   // rel offset for jmp

endmodule

// File: src/eip_unit.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module eip_unit
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  redirect_t             redir,
    input  logic                  accept,
    input  logic [LEN_W-1:0]      length,
    output logic [`DEC_EIP_W-1:0] eip
);

    logic [`DEC_EIP_W-1:0] redir_eip;   // chosen redirect target
    logic                  redir_any;
    logic [`DEC_EIP_W-1:0] seq_eip;     // fall through

    // init beats resteer beats bp
    always_comb begin
        redir_any = redir.init | redir.resteer | redir.bp_taken;
        if (redir.init) redir_eip = redir.init_eip;
        else if (redir.resteer) redir_eip = redir.resteer_eip;
        else redir_eip = redir.bp_eip;
    end

    assign seq_eip = eip + {{(`DEC_EIP_W-LEN_W){1'b0}}, length};

    always_ff @(posedge clk) begin
        if (reset) begin
            eip <= '0;
        end else if (redir_any) begin
            eip <= redir_eip;              // loads even while stalled
        end else if (accept) begin
            eip <= seq_eip;
        end
    end

endmodule

// File: src/decode_top.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_top
    import decode_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    input  packet_t          packet,
    input  logic             stall_in,
    input  redirect_t        redir,
    output logic             valid_out,
    output uop_t             uop,
    output logic             stall_out,
    output logic [LEN_W-1:0] d_length
);

    prefix_info_t          pfx;
    opcode_info_t          opc;
    modrm_info_t           mrm;
    logic [LEN_W-1:0]      length;
    logic [31:0]           disp;
    logic [31:0]           imm;
    logic [`DEC_EIP_W-1:0] eip;
    logic                  accept;
    uop_t                  uop_next;

    ////////////////////////////////////////////////////////////
    // field decode, all combinational
    prefix_decode prefix_decode_inst (.packet(packet), .pfx(pfx));

    opcode_decode opcode_decode_inst (.packet(packet), .pfx(pfx), .opc(opc));

    modrm_decode modrm_decode_inst (.packet(packet), .pfx(pfx), .opc(opc), .mrm(mrm));

    operand_extract operand_extract_inst (
        .packet(packet), .pfx(pfx), .opc(opc), .mrm(mrm),
        .length(length), .disp(disp), .imm(imm)
    );

    ////////////////////////////////////////////////////////////
    // handshake and eip
    assign accept = valid_in & ~stall_in & ~(redir.init | redir.resteer | redir.bp_taken);

    assign stall_out = stall_in;                     // straight back to fetch
    assign d_length  = valid_in ? length : '0;       // fetch shift amount

    eip_unit eip_unit_inst (
        .clk(clk), .reset(reset), .redir(redir),
        .accept(accept), .length(length), .eip(eip)
    );

    ////////////////////////////////////////////////////////////
    // uop assembly and output register
    always_comb begin
        uop_next          = '0;
        uop_next.eip      = eip;
        uop_next.next_eip = eip + {{(`DEC_EIP_W-LEN_W){1'b0}}, length};
        uop_next.length   = length;
        uop_next.pfx      = pfx;
        uop_next.opc      = opc;
        uop_next.mrm      = mrm;
        uop_next.disp     = disp;
        uop_next.imm      = imm;
        uop_next.ie       = opc.illegal;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
            uop       <= '0;
        end else if (!stall_in) begin    // stall freezes both
            valid_out <= accept;
            if (accept) uop <= uop_next;
        end
    end

endmodule

// File: dv/decode_props.sv
`timescale 1ns/1ns

module decode_props
    import decode_pkg::*;
(
    input logic             clk,
    input logic             reset,
    input logic             valid_in,
    input logic             stall_in,
    input logic             stall_out,
    input logic             valid_out,
    input uop_t             uop,
    input logic [LEN_W-1:0] d_length
);

    // nothing valid straight out of reset
    reset_clears_valid: assert property (@(posedge clk) reset |=> !valid_out)
        else $error("valid_out high in the cycle after reset");

    // stalled edge freezes the output register
    stall_holds_output: assert property (@(posedge clk) disable iff (reset)
        stall_in |=> $stable(uop) && $stable(valid_out))
        else $error("uop or valid_out changed across a stalled cycle");

    // fetch shift is nonzero exactly while a packet is offered
    length_tracks_valid: assert property (@(posedge clk) (d_length != '0) == valid_in)
        else $error("d_length disagrees with valid_in");

    stall_passthrough: assert property (@(posedge clk) stall_out == stall_in)
        else $error("stall_out does not follow stall_in");

endmodule

bind decode_top decode_props decode_props_inst (
    .clk(clk), .reset(reset), .valid_in(valid_in), .stall_in(stall_in),
    .stall_out(stall_out), .valid_out(valid_out), .uop(uop), .d_length(d_length)
);

// File: dv/decode_tb.sv
`timescale 1ns/1ns

module decode_tb
    import decode_pkg::*;
();

    localparam int NUM_LINES = 23;   // data lines in the stim file
    localparam int LINE_W    = 300;

    // one stim line, msb first as written in the file
    typedef struct packed {
        logic [3:0]  cmd;        // 0 packet, 1 redirect, 2 packet with redirect
        packet_t     pkt;
        logic [3:0]  rkind;      // init, resteer, bp in bits 2..0
        logic [31:0] reip;
        logic [3:0]  len;
        logic [31:0] disp;
        logic [31:0] imm;
        logic [3:0]  reg_num;
        logic [3:0]  base;
        logic [3:0]  index;
        logic [3:0]  scale;
        logic [3:0]  flags;      // use_base, use_index, has_sib
        logic [7:0]  pfx;
        logic [3:0]  ie;
        logic [31:0] next_eip;
    } stim_t;

    logic             clk;
    logic             reset;
    logic             valid_in;
    packet_t          packet;
    logic             stall_in;
    redirect_t        redir;
    logic             valid_out;
    uop_t             uop;
    logic             stall_out;
    logic [LEN_W-1:0] d_length;

    logic [LINE_W-1:0] stim_mem [NUM_LINES];
    logic [31:0]       lcg_state;
    logic [31:0]       eip_exp;     // where decode should be

    decode_top decode_top_inst (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;           // 10 ns period

    ////////////////////////////////////////////////////////////
    // helpers
    function automatic logic rand_stall();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31] & lcg_state[30];   // about one cycle in four
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "decode_tb stopped");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
            fail_run("value mismatch");
        end
    endtask

    // hold the packet until an unstalled edge takes it
    task automatic send_packet(input stim_t s);
        logic took;
        took     = 1'b0;
        valid_in = 1'b1;
        packet   = s.pkt;
        while (!took) begin
            stall_in = rand_stall();
            #1;
            check_field("d_length", 32'(d_length), 32'(s.len));
            @(posedge clk);
            took = !stall_in;
            @(negedge clk);
        end
        check_field("valid_out", 32'(valid_out), 32'd1);   // one cycle later
        check_field("uop.eip", uop.eip, eip_exp);
        check_field("uop.next_eip", uop.next_eip, s.next_eip);
        check_field("uop.length", 32'(uop.length), 32'(s.len));
        check_field("uop.disp", uop.disp, s.disp);
        check_field("uop.imm", uop.imm, s.imm);
        check_field("uop.mrm.reg_num", 32'(uop.mrm.reg_num), 32'(s.reg_num));
        check_field("uop.mrm.base", 32'(uop.mrm.base), 32'(s.base));
        check_field("uop.mrm.index", 32'(uop.mrm.index), 32'(s.index));
        check_field("uop.mrm.scale", 32'(uop.mrm.scale), 32'(s.scale));
        check_field("uop.mrm flags", {29'd0, uop.mrm.use_base, uop.mrm.use_index,
                    uop.mrm.has_sib}, 32'(s.flags));
        check_field("uop.pfx", {25'd0, uop.pfx}, 32'(s.pfx));
        check_field("uop.ie", 32'(uop.ie), 32'(s.ie));
        eip_exp  = s.next_eip;      // next uop continues here
        valid_in = 1'b0;
    endtask

    // winning source gets the stim target, lower ones get a decoy
    task automatic apply_redirect(input stim_t s);
        logic was_valid;
        was_valid         = valid_out;
        valid_in          = (s.cmd == 4'd2);
        packet            = s.pkt;
        redir             = '0;
        redir.init        = s.rkind[2];
        redir.resteer     = s.rkind[1];
        redir.bp_taken    = s.rkind[0];
        redir.init_eip    = s.reip;
        redir.resteer_eip = s.rkind[2] ? ~s.reip : s.reip;
        redir.bp_eip      = (s.rkind[2] | s.rkind[1]) ? s.reip ^ 32'h00ff_0000 : s.reip;
        // a bare redirect still loads under stall
        // the dropped packet only shows on an unstalled edge
        stall_in          = (s.cmd != 4'd2);
        @(posedge clk);
        @(negedge clk);
        // same cycle packet is dropped
        check_field("valid_out", 32'(valid_out), stall_in ? 32'(was_valid) : 32'd0);
        eip_exp  = s.reip;
        valid_in = 1'b0;
        redir    = '0;
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    initial begin
        stim_t s;
        lcg_state = 32'hef36_b19d;
        eip_exp   = '0;
        valid_in  = 1'b0;
        packet    = '0;
        stall_in  = 1'b0;
        redir     = '0;
        reset     = 1'b1;
        $readmemh("dv/decode_stim.txt", stim_mem);
        assert (!$isunknown(stim_mem[NUM_LINES-1]))
            else fail_run("stim file dv/decode_stim.txt is missing or too short");
        repeat (10) @(negedge clk);
        reset = 1'b0;
        check_field("valid_out", 32'(valid_out), 32'd0);
        check_field("uop any bit", {31'd0, |uop}, 32'd0);   // cleared by reset
        for (int i = 0; i < NUM_LINES; i++) begin
            s = stim_t'(stim_mem[i]);
            if (s.cmd == 4'd0) send_packet(s);
            else apply_redirect(s);
        end
        @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

    // watchdog, 40 cycles per stim line plus reset
    initial begin
        #((NUM_LINES * 40 + 10) * 10);
        fail_run("timeout, the decode stage stopped accepting packets");
    end

endmodule

// File: dv/decode_stim.txt
// cmd _ packet _ rkind _ reip _ len _ disp _ imm _ reg _ base _ index _ scale _ flags _ pfx _ ie _ next_eip
1_00000000_00000000_00000000_00000000_4_00001000_0_00000000_00000000_0_0_0_0_0_00_0_00000000
0_01d8cccc_cccccccc_cccccccc_cccccccc_0_00000000_2_00000000_00000000_3_0_0_0_4_00_0_00001002
0_8b45f8cc_cccccccc_cccccccc_cccccccc_0_00000000_3_fffffff8_00000000_0_5_0_0_4_00_0_00001005
0_03048d78_563412cc_cccccccc_cccccccc_0_00000000_7_12345678_00000000_0_0_1_2_3_00_0_0000100c
0_898ce300_010000cc_cccccccc_cccccccc_0_00000000_7_00000100_00000000_1_3_0_0_5_00_0_00001013
0_880d4433_2211cccc_cccccccc_cccccccc_0_00000000_6_11223344_00000000_1_0_0_0_0_00_0_00001019
0_05785634_12cccccc_cccccccc_cccccccc_0_00000000_5_00000000_12345678_0_0_0_0_0_00_0_0000101e
0_660534f2_cccccccc_cccccccc_cccccccc_0_00000000_4_00000000_fffff234_0_0_0_0_0_28_0_00001022
0_81c3ff00_0000cccc_cccccccc_cccccccc_0_00000000_6_00000000_000000ff_0_3_0_0_4_00_0_00001028
0_834610fe_cccccccc_cccccccc_cccccccc_0_00000000_4_00000010_fffffffe_0_6_0_0_4_00_0_0000102c
0_f32e6590_cccccccc_cccccccc_cccccccc_0_00000000_4_00000000_00000000_0_0_0_0_0_76_0_00001030
0_2666b934_12cccccc_cccccccc_cccccccc_0_00000000_5_00000000_00001234_1_0_0_0_0_49_0_00001035
0_363e64eb_05cccccc_cccccccc_cccccccc_0_00000000_5_00000000_00000005_0_0_0_0_0_65_0_0000103a
0_3e0fcccc_cccccccc_cccccccc_cccccccc_0_00000000_2_00000000_00000000_0_0_0_0_0_24_1_0000103c
0_c3cccccc_cccccccc_cccccccc_cccccccc_0_00000000_1_00000000_00000000_0_0_0_0_0_00_1_0000103d
0_e9000100_00cccccc_cccccccc_cccccccc_0_00000000_5_00000000_00000100_0_0_0_0_0_00_0_00001042
2_90cccccc_cccccccc_cccccccc_cccccccc_1_0000214b_0_00000000_00000000_0_0_0_0_0_00_0_00000000
0_90cccccc_cccccccc_cccccccc_cccccccc_0_00000000_1_00000000_00000000_0_0_0_0_0_00_0_0000214c
1_00000000_00000000_00000000_00000000_7_00003000_0_00000000_00000000_0_0_0_0_0_00_0_00000000
0_90cccccc_cccccccc_cccccccc_cccccccc_0_00000000_1_00000000_00000000_0_0_0_0_0_00_0_00003001
1_00000000_00000000_00000000_00000000_3_00004000_0_00000000_00000000_0_0_0_0_0_00_0_00000000
0_90cccccc_cccccccc_cccccccc_cccccccc_0_00000000_1_00000000_00000000_0_0_0_0_0_00_0_00004001
0_6681c0ff_ffcccccc_cccccccc_cccccccc_0_00000000_5_00000000_ffffffff_0_0_0_0_4_28_0_00004006

// File: tb.f
+incdir+src
src/decode_pkg.sv
src/prefix_decode.sv
src/opcode_decode.sv
src/modrm_decode.sv
src/operand_extract.sv
src/eip_unit.sv
src/decode_top.sv
dv/decode_props.sv
dv/decode_tb.sv

// File: Makefile
# Verilator build and run for the decode stage
VERILATOR ?= verilator
TOP       ?= decode_tb
LOG       ?= sim.log
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, fail if $(LOG) reports a failure"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) \
		> $(LOG) 2>&1 || { cat $(LOG); exit 1; }
	-./$(OBJ_DIR)/V$(TOP) >> $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "decode test failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
